// ==== files.f ====
hw/tapper_pkg.sv
hw/tick_gen.sv
hw/player_ctrl.sv
hw/lane_unit.sv
hw/level_fsm.sv
hw/score_display.sv
hw/tapper_top.sv
test/tapper_assertions.sv
test/tapper_tb.sv

// ==== hw/lane_unit.sv ====
module lane_unit #(
	parameter int BASE_STEP = 1
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       run,
	input  logic       restart,
	input  logic       throw,
	input  logic       cup_tick,
	input  logic       cust_tick,
	input  logic [3:0] speed,
	output logic       cup_active,
	output logic       hit,
	output logic       overrun
);

	tapper_pkg::coord_t cup_x;
	tapper_pkg::coord_t cust_x;
	tapper_pkg::coord_t step;

	// Customer advance per tick
	assign step = tapper_pkg::coord_t'(BASE_STEP) + {6'd0, speed};

	// Cup close enough to the customer scores
	assign hit = run && cup_active && (cup_x <= cust_x + tapper_pkg::HIT_REACH);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cup_active <= 1'b0;
			overrun    <= 1'b0;
			cup_x      <= tapper_pkg::BAR_X;
			cust_x     <= tapper_pkg::CUST_MIN_X;
		end
		else if (restart)
		begin
			cup_active <= 1'b0;
			overrun    <= 1'b0;
			cup_x      <= tapper_pkg::BAR_X;
			cust_x     <= tapper_pkg::CUST_MIN_X;
		end
		else if (hit)
		begin
			// Served customer goes back to the door
			cup_active <= 1'b0;
			cup_x      <= tapper_pkg::BAR_X;
			cust_x     <= tapper_pkg::CUST_MIN_X;
		end
		else
		begin
			if (throw && !cup_active)
				cup_active <= 1'b1;
			else if (cup_tick && cup_active && cup_x > cust_x)
				cup_x <= cup_x - 1'b1;

			if (cust_tick)
			begin
				if (cust_x >= tapper_pkg::CUST_MAX_X)
					overrun <= 1'b1; // Held until the next restart
				else
					cust_x <= cust_x + step;
			end
		end
	end

endmodule

// ==== hw/level_fsm.sv ====
module level_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               key0, // Active low
	input  logic [3:0]         hit,
	input  logic [3:0]         overrun,
	output logic               run,
	output logic               restart,
	output logic [3:0]         speed,
	output tapper_pkg::score_t score,
	output logic [7:0]         level_leds,
	output logic               game_over,
	output logic               game_won
);

	tapper_pkg::level_t state;
	tapper_pkg::level_t state_next;
	logic [2:0]         hit_count;

	assign run = state inside {tapper_pkg::run1, tapper_pkg::run2, tapper_pkg::run3};
	assign game_over = (state == tapper_pkg::lost);
	assign game_won  = (state == tapper_pkg::won);
	assign hit_count = 3'(hit[0]) + 3'(hit[1]) + 3'(hit[2]) + 3'(hit[3]);

	always_comb
	begin
		state_next = state;
		case (state)
			tapper_pkg::start1: if (!key0) state_next = tapper_pkg::run1;
			tapper_pkg::run1: if (score >= tapper_pkg::LEVEL1_SCORE) state_next = tapper_pkg::start2;
			tapper_pkg::start2: if (!key0) state_next = tapper_pkg::run2;
			tapper_pkg::run2: if (score >= tapper_pkg::LEVEL2_SCORE) state_next = tapper_pkg::start3;
			tapper_pkg::start3: if (!key0) state_next = tapper_pkg::run3;
			tapper_pkg::run3: if (score >= tapper_pkg::LEVEL3_SCORE) state_next = tapper_pkg::won;
			default: state_next = state; // won and lost are final
		endcase
		if (run && |overrun)
			state_next = tapper_pkg::lost;
	end

	always_comb
	begin
		case (state)
			tapper_pkg::start1, tapper_pkg::run1: speed = tapper_pkg::LEVEL1_SPEED;
			tapper_pkg::start2, tapper_pkg::run2: speed = tapper_pkg::LEVEL2_SPEED;
			tapper_pkg::start3, tapper_pkg::run3: speed = tapper_pkg::LEVEL3_SPEED;
			default: speed = 4'd0;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state      <= tapper_pkg::start1;
			restart    <= 1'b1; // One pulse out of reset
			score      <= '0;
			level_leds <= 8'd1;
		end
		else
		begin
			state   <= state_next;
			restart <= (state_next != state) &&
				(state_next inside {tapper_pkg::start1, tapper_pkg::start2, tapper_pkg::start3});
			score   <= score + tapper_pkg::score_t'(hit_count);
			if (state_next == tapper_pkg::start2)
				level_leds <= 8'd3;
			else if (state_next == tapper_pkg::start3)
				level_leds <= 8'd7;
		end
	end

endmodule

// ==== hw/player_ctrl.sv ====
module player_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic [3:0]        key, // Active low
	input  logic              run,
	input  logic              restart,
	input  logic              move_tick,
	output tapper_pkg::lane_t lane,
	output logic              at_bar,
	output logic [3:0]        throw
);

	logic [3:0]         key_prev;
	logic [3:0]         key_fall;
	tapper_pkg::coord_t x;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			key_prev <= '1;
		else
			key_prev <= key;
	end

	assign key_fall = key_prev & ~key;
	assign at_bar   = (x == tapper_pkg::BAR_X);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			lane  <= '0;
			x     <= tapper_pkg::BAR_X;
			throw <= '0;
		end
		else if (restart)
		begin
			lane  <= '0; // Back to the top row at the bar
			x     <= tapper_pkg::BAR_X;
			throw <= '0;
		end
		else
		begin
			if (run && key_fall[3])
				lane <= lane + 2'd1; // Down, wraps 3 to 0
			else if (run && key_fall[2])
				lane <= lane - 2'd1;

			// Step off the bar while key1 is held
			if (move_tick)
			begin
				if (key[1])
					x <= tapper_pkg::BAR_X;
				else if (x != '0)
					x <= x - 1'b1;
			end

			throw <= (run && at_bar && key_fall[0]) ? (4'b0001 << lane) : 4'b0000;
		end
	end

endmodule

// ==== hw/score_display.sv ====
module score_display (
	input  tapper_pkg::score_t score,
	output logic [6:0]         hex0,
	output logic [6:0]         hex1,
	output logic [6:0]         hex2,
	output logic [6:0]         hex3
);

	logic [3:0] ones;
	logic [3:0] tens;
	logic [3:0] hundreds;

	// Segment order gfedcba, a lit segment is 0
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0: seg7 = 7'b1000000;
			4'd1: seg7 = 7'b1111001;
			4'd2: seg7 = 7'b0100100;
			4'd3: seg7 = 7'b0110000;
			4'd4: seg7 = 7'b0011001;
			4'd5: seg7 = 7'b0010010;
			4'd6: seg7 = 7'b0000010;
			4'd7: seg7 = 7'b1111000;
			4'd8: seg7 = 7'b0000000;
			4'd9: seg7 = 7'b0010000;
			default: seg7 = 7'b1111111;
		endcase
	endfunction

	assign ones     = 4'(score % 8'd10);
	assign tens     = 4'((score / 8'd10) % 8'd10);
	assign hundreds = 4'(score / 8'd100);

	assign hex0 = seg7(ones);
	assign hex1 = seg7(tens);
	assign hex2 = seg7(hundreds);
	assign hex3 = 7'b1111111; // Sign digit, score is never negative

endmodule

// ==== hw/tapper_pkg.sv ====
package tapper_pkg;

	// Screen coordinate, lane index and score
	typedef logic [9:0] coord_t;
	typedef logic [1:0] lane_t; // 0 is the top row
	typedef logic [7:0] score_t;

	// Game flow states
	typedef enum logic [2:0]
	{
		start1 = 3'd0,
		run1   = 3'd1,
		start2 = 3'd2,
		run2   = 3'd3,
		start3 = 3'd4,
		run3   = 3'd5,
		won    = 3'd6,
		lost   = 3'd7
	} level_t;

	localparam coord_t BAR_X      = 10'd400; // Player home and cup launch point
	localparam coord_t CUST_MIN_X = 10'd60;
	localparam coord_t CUST_MAX_X = 10'd380; // Customer here means the game is lost
	localparam coord_t HIT_REACH  = 10'd20;

	// Score needed to clear each level
	localparam score_t LEVEL1_SCORE = 8'd12;
	localparam score_t LEVEL2_SCORE = 8'd24;
	localparam score_t LEVEL3_SCORE = 8'd36;

	// Extra customer step per level
	localparam logic [3:0] LEVEL1_SPEED = 4'd1;
	localparam logic [3:0] LEVEL2_SPEED = 4'd5;
	localparam logic [3:0] LEVEL3_SPEED = 4'd10;

	// Base customer step, indexed by lane
	localparam logic [3:0][3:0] LANE_BASE_STEP = {4'd1, 4'd1, 4'd2, 4'd3};

	localparam int DELAY_W = 32;

endpackage

// ==== hw/tapper_top.sv ====
module tapper_top #(
	parameter int unsigned MOVE_DELAY     = 2000000,
	parameter int unsigned CUP_DELAY      = 1000000,
	parameter int unsigned CUSTOMER_DELAY = 2000980
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [3:0]         key, // Active low
	output logic [6:0]         hex0,
	output logic [6:0]         hex1,
	output logic [6:0]         hex2,
	output logic [6:0]         hex3,
	output logic [7:0]         level_leds,
	output logic               game_over,
	output logic               game_won,
	output tapper_pkg::lane_t  player_lane,
	output logic               player_at_bar,
	output logic [3:0]         cup_active
);

	logic               run;
	logic               restart;
	logic               move_tick;
	logic               cup_tick;
	logic               cust_tick;
	logic [3:0]         throw;
	logic [3:0]         hit;
	logic [3:0]         overrun;
	logic [3:0]         speed;
	tapper_pkg::score_t score;

	// Timers for player steps, cup travel and customer walk
	tick_gen #(.DELAY(MOVE_DELAY)) move_tick_i (
		.clk(clk), .rst(rst), .enable(run), .restart(restart), .tick(move_tick)
	);
	tick_gen #(.DELAY(CUP_DELAY)) cup_tick_i (
		.clk(clk), .rst(rst), .enable(run), .restart(restart), .tick(cup_tick)
	);
	tick_gen #(.DELAY(CUSTOMER_DELAY)) cust_tick_i (
		.clk(clk), .rst(rst), .enable(run), .restart(restart), .tick(cust_tick)
	);

	player_ctrl player_i (
		.clk(clk), .rst(rst), .key(key), .run(run), .restart(restart),
		.move_tick(move_tick), .lane(player_lane), .at_bar(player_at_bar), .throw(throw)
	);

	for (genvar i = 0; i < 4; i++)
	begin : g_lane
		lane_unit #(.BASE_STEP(tapper_pkg::LANE_BASE_STEP[i])) lane_i (
			.clk(clk), .rst(rst), .run(run), .restart(restart), .throw(throw[i]),
			.cup_tick(cup_tick), .cust_tick(cust_tick), .speed(speed),
			.cup_active(cup_active[i]), .hit(hit[i]), .overrun(overrun[i])
		);
	end

	level_fsm level_i (
		.clk(clk), .rst(rst), .key0(key[0]), .hit(hit), .overrun(overrun),
		.run(run), .restart(restart), .speed(speed), .score(score),
		.level_leds(level_leds), .game_over(game_over), .game_won(game_won)
	);

	score_display display_i (
		.score(score), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3)
	);

endmodule

// ==== hw/tick_gen.sv ====
module tick_gen #(
	parameter int unsigned DELAY = 0
) (
	input  logic clk,
	input  logic rst,
	input  logic enable,
	input  logic restart,
	output logic tick
);

	localparam logic [tapper_pkg::DELAY_W-1:0] LAST = DELAY;

	logic [tapper_pkg::DELAY_W-1:0] count;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			count <= '0;
		else if (restart)
			count <= '0; // Align ticks to the level start
		else if (enable)
		begin
			if (count == LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	assign tick = enable && (count == LAST);

endmodule

// ==== test/tapper_assertions.sv ====
module tapper_assertions (
	input logic       clk,
	input logic       rst,
	input logic [3:0] hit,
	input logic       game_over,
	input logic       game_won
);

	for (genvar i = 0; i < 4; i++)
	begin : g_hit
		// Scoring cup leaves the lane on the next clock
		hit_one_cycle: assert property (@(posedge clk) disable iff (!rst) hit[i] |=> !hit[i])
			else $error("hit on lane %0d held for more than one cycle", i);
	end

	over_won_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(game_over && game_won))
		else $error("game_over and game_won high together");

	// Lost is a final state
	over_holds: assert property (@(posedge clk) disable iff (!rst) game_over |=> game_over)
		else $error("game_over dropped without a reset");

endmodule

bind tapper_top tapper_assertions assertions_i (
	.clk(clk), .rst(rst), .hit(hit), .game_over(game_over), .game_won(game_won)
);

// ==== test/tapper_tb.sv ====
module tapper_tb;

	localparam int ACT_RESET      = 0;
	localparam int ACT_PRESS      = 1; // Falling edge on key[arg]
	localparam int ACT_KEY1       = 2; // Hold (arg 0) or release (arg 1)
	localparam int ACT_WAIT_HIT   = 3; // Cup on lane arg lands
	localparam int ACT_WAIT_SCORE = 4; // Score, LEDs and end flags all match
	localparam int ACT_IDLE       = 5;
	localparam int STATUS_ANY     = 255; // Score, LEDs and win left out

	localparam int BAR_TIMEOUT   = 20;
	localparam int HIT_TIMEOUT   = 1000;
	// Lane 0 walks 4 px per 16 cycle tick from 60 to 380
	localparam int SCORE_TIMEOUT = 81 * 16 + 64;

	// Digits 0 to 9, gfedcba, lit segment is 0
	localparam logic [6:0] SEG_PATTERN [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

	typedef struct packed {
		logic [2:0] action;
		logic [7:0] arg;
		logic [1:0] lane;
		logic       at_bar;
		logic [3:0] cups;
		logic [3:0] cup_mask;
		logic [7:0] score;
		logic [7:0] leds;
		logic       over;
		logic       won;
	} step_t;

	logic       clk;
	logic       rst;
	logic [3:0] key;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [7:0] level_leds;
	logic       game_over;
	logic       game_won;
	logic [1:0] player_lane;
	logic       player_at_bar;
	logic [3:0] cup_active;

	step_t steps[$];
	int    value_errors;
	int    timeouts;
	bit    abort;

	tapper_top #(.MOVE_DELAY(3), .CUP_DELAY(0), .CUSTOMER_DELAY(15)) dut_i (
		.clk(clk), .rst(rst), .key(key), .hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .level_leds(level_leds), .game_over(game_over), .game_won(game_won),
		.player_lane(player_lane), .player_at_bar(player_at_bar), .cup_active(cup_active)
	);

	always #5 clk = ~clk;

	task automatic add_step(input int action, arg, lane, at_bar, cups, cup_mask,
		score, leds, over, won);
		step_t s;
		s = {3'(action), 8'(arg), 2'(lane), 1'(at_bar), 4'(cups), 4'(cup_mask), 8'(score),
			8'(leds), 1'(over), 1'(won)};
		steps.push_back(s);
	endtask

	// Serve every lane top to bottom, then wait for all four cups
	task automatic add_round(input int score, input int leds);
		for (int lane = 0; lane < 4; lane++)
		begin
			add_step(ACT_PRESS, 0, lane, 1, (2 << lane) - 1, 4'hf, score, leds, 0, 0);
			add_step(ACT_PRESS, 3, (lane + 1) % 4, 1, (2 << lane) - 1, 4'hf, score, leds, 0, 0);
		end
		for (int lane = 0; lane < 4; lane++)
			add_step(ACT_WAIT_HIT, lane, 0, 1, 0, 1 << lane, STATUS_ANY, 0, 0, 0);
	endtask

	task automatic build_table();
		int score;
		int leds;
		int next_leds;
		score = 0;
		add_step(ACT_RESET, 0, 0, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 0, 0, 1, 0, 4'hf, 0, 1, 0, 0); // Start level 1
		add_step(ACT_PRESS, 3, 1, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 3, 2, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 3, 3, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 3, 0, 1, 0, 4'hf, 0, 1, 0, 0); // Wraps down
		add_step(ACT_PRESS, 2, 3, 1, 0, 4'hf, 0, 1, 0, 0); // Wraps up
		add_step(ACT_PRESS, 3, 0, 1, 0, 4'hf, 0, 1, 0, 0);
		// No throw while off the bar
		add_step(ACT_KEY1, 0, 0, 0, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 0, 0, 0, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_KEY1, 1, 0, 1, 0, 4'hf, 0, 1, 0, 0);
		for (int level = 1; level <= 3; level++)
		begin
			leds = (1 << level) - 1;
			next_leds = (level < 3) ? (1 << (level + 1)) - 1 : leds;
			if (level > 1)
			begin
				add_step(ACT_PRESS, 3, 0, 1, 0, 4'hf, score, leds, 0, 0); // Frozen start screen
				add_step(ACT_PRESS, 0, 0, 1, 0, 4'hf, score, leds, 0, 0);
			end
			for (int round = 0; round < 3; round++)
			begin
				add_round(score, leds);
				score += 4;
				add_step(ACT_WAIT_SCORE, 0, 0, 1, 0, 4'hf, score,
					(round == 2) ? next_leds : leds, 0, level == 3 && round == 2);
			end
			add_step(ACT_IDLE, 40, 0, 1, 0, 4'hf, score, next_leds, 0, level == 3);
		end
		// Unserved customer reaches the bar
		add_step(ACT_RESET, 0, 0, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_PRESS, 0, 0, 1, 0, 4'hf, 0, 1, 0, 0);
		add_step(ACT_WAIT_SCORE, 0, 0, 1, 0, 4'hf, 0, 1, 1, 0);
	endtask

	function automatic logic [6:0] digit_pattern(input int value, input int place);
		return SEG_PATTERN[(value / place) % 10];
	endfunction

	function automatic bit status_matches(input step_t s);
		return hex0 == digit_pattern(s.score, 1) && hex1 == digit_pattern(s.score, 10) &&
			hex2 == digit_pattern(s.score, 100) && level_leds == s.leds &&
			game_won == s.won && game_over == s.over;
	endfunction

	task automatic check_field(input string name, input string field, input int expected,
		input int actual);
		assert (expected == actual)
		else
		begin
			$display("Fail %s %s: expected 'h%0h, actual 'h%0h", name, field, expected, actual);
			value_errors++;
		end
	endtask

	task automatic report_timeout(input string name, input string what);
		$display("Timeout in %s: %s", name, what);
		timeouts++;
		abort = 1'b1;
	endtask

	task automatic apply_step(input int idx, input step_t s);
		string name;
		int    n;
		n = 0;
		case (s.action)
			ACT_RESET:
			begin
				name = $sformatf("reset[%0d]", idx);
				@(posedge clk);
				rst <= 1'b0;
				key <= 4'hf;
				repeat (8) @(posedge clk);
				rst <= 1'b1;
			end
			ACT_PRESS:
			begin
				name = $sformatf("press_key%0d[%0d]", s.arg, idx);
				@(posedge clk);
				key[s.arg] <= 1'b0;
				@(posedge clk);
				key[s.arg] <= 1'b1;
				repeat (2) @(posedge clk);
			end
			ACT_KEY1:
			begin
				name = $sformatf("%s[%0d]", s.arg[0] ? "release_key1" : "hold_key1", idx);
				@(posedge clk);
				key[1] <= s.arg[0];
				@(negedge clk);
				while (player_at_bar != s.arg[0] && n < BAR_TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				assert (n < BAR_TIMEOUT) else report_timeout(name, "player_at_bar ignored key1");
			end
			ACT_WAIT_HIT:
			begin
				name = $sformatf("wait_hit_lane%0d[%0d]", s.arg, idx);
				while (cup_active[s.arg] && n < HIT_TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				assert (n < HIT_TIMEOUT) else report_timeout(name, "cup never reached the customer");
			end
			ACT_WAIT_SCORE:
			begin
				name = $sformatf("wait_score%0d[%0d]", s.score, idx);
				while (!status_matches(s) && n < SCORE_TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				assert (n < SCORE_TIMEOUT) else report_timeout(name, "score or game state never arrived");
			end
			default:
			begin
				name = $sformatf("idle[%0d]", idx);
				repeat (s.arg) @(posedge clk);
			end
		endcase
		@(negedge clk); // Outputs settled
		check_field(name, "player_lane", s.lane, player_lane);
		check_field(name, "player_at_bar", s.at_bar, player_at_bar);
		check_field(name, "cup_active", s.cups & s.cup_mask, cup_active & s.cup_mask);
		check_field(name, "game_over", s.over, game_over);
		check_field(name, "hex3", 7'h7f, hex3);
		if (s.score != STATUS_ANY)
		begin
			check_field(name, "hex0", digit_pattern(s.score, 1), hex0);
			check_field(name, "hex1", digit_pattern(s.score, 10), hex1);
			check_field(name, "hex2", digit_pattern(s.score, 100), hex2);
			check_field(name, "level_leds", s.leds, level_leds);
			check_field(name, "game_won", s.won, game_won);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;
		key = 4'hf; // Keys idle high
		value_errors = 0;
		timeouts = 0;
		abort = 1'b0;
		build_table();
		for (int i = 0; i < steps.size() && !abort; i++)
			apply_step(i, steps[i]);
		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
